//--- logic/agu_pkg.sv
`default_nettype none

package agu_pkg;

  // data cache line geometry
  localparam int bank_count = 32;
  localparam int line_bytes = 128;
  localparam int page_bits = 13;
  localparam int paddr_width = 44;

  typedef logic [bank_count-1:0] bank_mask_t;
  typedef logic [$clog2(bank_count)-1:0] bank_idx_t;
  // line pair address, physical bits 43 down to 8
  typedef logic [paddr_width-9:0] line_addr_t;

  typedef logic [8:0] reg_no_t;
  typedef logic [8:0] lsq_no_t;
  typedef logic [9:0] ii_no_t;
  typedef logic [7:0] wq_no_t;

  // bit 0 is store, bits 5..1 hold the size code
  typedef logic [12:0] op_t;

  // sz_ldbl is 10 bytes, sz_fill always spans five banks
  typedef enum logic [2:0] {
    sz_byte,
    sz_half,
    sz_word,
    sz_dword,
    sz_ldbl,
    sz_quad,
    sz_fill
  } size_class_e;

  typedef struct packed {
    op_t         op;
    logic [63:0] vaddr;
    reg_no_t     regno;
    lsq_no_t     lsq;
    ii_no_t      ii;
    wq_no_t      wq;
    logic        thread;
    logic        lsflag;
  } agu_req_t;

  typedef struct packed {
    op_t                    op;
    reg_no_t                regno;
    lsq_no_t                lsq;
    ii_no_t                 ii;
    wq_no_t                 wq;
    logic                   thread;
    logic                   lsflag;
    bank_mask_t             banks;
    bank_idx_t              bank0;
    logic                   odd;
    logic [1:0]             addr_low;
    logic                   split;
    line_addr_t             addr_even;
    line_addr_t             addr_odd;
    logic [paddr_width-1:0] addr_main;
    logic [1:0]             mtype;
  } mem_op_t;

endpackage

`default_nettype wire

//--- logic/dtlb_pkg.sv
`default_nettype none

package dtlb_pkg;

  typedef logic [20:0] proc_id_t;
  // virtual address bits 43..13
  typedef logic [30:0] vpn_t;
  typedef logic [30:0] ppn_t;

  typedef struct packed {
    ppn_t       ppn;
    logic [1:0] mtype;
    logic       sys;
    logic       perm;
  } tlb_entry_t;

  // way is wide enough for up to 8 ways
  typedef struct packed {
    logic       valid;
    logic [2:0] way;
    proc_id_t   proc;
    vpn_t       vpn;
    tlb_entry_t entry;
  } tlb_write_t;

  typedef struct packed {
    logic        en;
    logic [15:0] no;
    logic [63:0] data;
  } csr_write_t;

  // page csr carries the process id in bits 63..40
  localparam logic [15:0] csr_page = 16'h0010;
  localparam logic [15:0] csr_mflags = 16'h0011;

  typedef logic [1:0] cpl_t;
  localparam cpl_t cpl_kernel = 2'd0;
  localparam cpl_t cpl_user = 2'd3;

  typedef logic [7:0] fault_code_t;
  localparam int fault_this_bit = 0;
  localparam int fault_next_bit = 1;

endpackage

`default_nettype wire

//--- logic/agu_bank_map.sv
`default_nettype none

module agu_bank_map (
  input  agu_pkg::op_t       op,
  input  logic [6:0]         addr_low,
  output agu_pkg::bank_mask_t banks,
  output agu_pkg::bank_idx_t  bank0,
  output logic               split
);

  import agu_pkg::*;

  size_class_e size_class;
  logic [4:0]  size_bytes;
  logic [4:0]  span;
  logic [4:0]  span_round;
  logic [2:0]  nbanks;
  logic [4:0]  offs;

  assign bank0 = addr_low[6:2];

  // size code decode
  always_comb begin
    case (op[5:1])
      5'd16: size_class = sz_byte;
      5'd17: size_class = sz_half;
      5'd18: size_class = sz_word;
      5'd19: size_class = sz_dword;
      5'd3: size_class = sz_ldbl;
      // 128 bit int and float forms
      5'd0, 5'd1, 5'd2: size_class = sz_quad;
      5'd12, 5'd13, 5'd14: size_class = sz_quad;
      5'd4, 5'd5, 5'd6: size_class = sz_word;
      5'd8, 5'd9, 5'd10: size_class = sz_dword;
      5'd15: size_class = sz_fill;
      default: size_class = sz_dword;
    endcase
  end

  always_comb begin
    case (size_class)
      sz_byte: size_bytes = 5'd1;
      sz_half: size_bytes = 5'd2;
      sz_word: size_bytes = 5'd4;
      sz_dword: size_bytes = 5'd8;
      sz_ldbl: size_bytes = 5'd10;
      default: size_bytes = 5'd16;
    endcase
  end

  // banks touched, rounded up from the word offset
  assign span = {3'b000, addr_low[1:0]} + size_bytes;
  assign span_round = span + 5'd3;

  always_comb begin
    if (size_class == sz_fill) begin
      nbanks = 3'd5;
    end else begin
      nbanks = span_round[4:2];
    end
  end

  // mask runs upward from bank0 and wraps at 32
  always_comb begin
    offs = '0;
    for (int i = 0; i < bank_count; i++) begin
      offs = 5'(i) - bank0;
      banks[i] = offs < {2'b00, nbanks};
    end
  end

  // range ends past the last bank
  assign split = ({1'b0, bank0} + {3'b000, nbanks}) > 6'(bank_count);

endmodule

`default_nettype wire

//--- logic/agu_bank_conflict.sv
`default_nettype none

module agu_bank_conflict (
  input  logic                valid,
  input  agu_pkg::bank_mask_t banks,
  input  agu_pkg::bank_mask_t other0_banks,
  input  agu_pkg::bank_mask_t other1_banks,
  input  agu_pkg::bank_mask_t otherR_banks,
  input  logic                other_flip,
  input  logic                bus_hold,
  output agu_pkg::bank_mask_t granted,
  output logic                conflict
);

  import agu_pkg::*;

  bank_mask_t lost;

  // flip picks which of the two ports ranks ahead of us
  always_comb begin
    for (int i = 0; i < bank_count; i++) begin
      lost[i] = banks[i] &
        (otherR_banks[i] | (other_flip ? other1_banks[i] : other0_banks[i]));
    end
  end

  assign granted = banks & ~lost;

  // held bus drops the report
  assign conflict = valid & ~bus_hold & (|lost);

endmodule

`default_nettype wire

//--- logic/dtlb.sv
`default_nettype none

module dtlb #(
  parameter int tlb_ways = 4
) (
  input  logic                 clk,
  input  logic                 rst,
  input  dtlb_pkg::proc_id_t   proc,
  input  dtlb_pkg::vpn_t       vpn,
  output logic                 hit,
  output dtlb_pkg::tlb_entry_t entry,
  output logic                 hit_next,
  output dtlb_pkg::tlb_entry_t entry_next,
  input  dtlb_pkg::tlb_write_t wr
);

  import dtlb_pkg::*;

  logic [tlb_ways-1:0] valid_q;
  proc_id_t            tag_proc_q [tlb_ways];
  vpn_t                tag_vpn_q [tlb_ways];
  tlb_entry_t          entry_q [tlb_ways];

  vpn_t                vpn_next;
  logic [tlb_ways-1:0] match;
  logic [tlb_ways-1:0] match_next;

  // second lookup serves lines that cross into the next page
  assign vpn_next = vpn + vpn_t'(1);

  always_comb begin
    for (int w = 0; w < tlb_ways; w++) begin
      match[w] = valid_q[w] && tag_proc_q[w] == proc && tag_vpn_q[w] == vpn;
      match_next[w] = valid_q[w] && tag_proc_q[w] == proc && tag_vpn_q[w] == vpn_next;
    end
  end

  assign hit = |match;
  assign hit_next = |match_next;

  // ways are kept unique by the refill logic, so or-select is enough
  always_comb begin
    entry = '0;
    entry_next = '0;
    for (int w = 0; w < tlb_ways; w++) begin
      if (match[w]) begin
        entry = entry | entry_q[w];
      end
      if (match_next[w]) begin
        entry_next = entry_next | entry_q[w];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
      for (int w = 0; w < tlb_ways; w++) begin
        tag_proc_q[w] <= '0;
        tag_vpn_q[w] <= '0;
        entry_q[w] <= '0;
      end
    end else if (wr.valid) begin
      for (int w = 0; w < tlb_ways; w++) begin
        if (wr.way == 3'(w)) begin
          valid_q[w] <= 1'b1;
          tag_proc_q[w] <= wr.proc;
          tag_vpn_q[w] <= wr.vpn;
          entry_q[w] <= wr.entry;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/agu_mode_state.sv
`default_nettype none

module agu_mode_state (
  input  logic                 clk,
  input  logic                 rst,
  input  dtlb_pkg::csr_write_t csr_wr,
  input  logic                 except,
  input  logic                 except_gate,
  input  logic                 except_in_km,
  output dtlb_pkg::proc_id_t   proc,
  output dtlb_pkg::cpl_t       cpl
);

  import dtlb_pkg::*;

  logic page_wr;
  logic mflags_wr;
  logic except_take;

  assign page_wr = csr_wr.en && csr_wr.no == csr_page;
  assign mflags_wr = csr_wr.en && csr_wr.no == csr_mflags;
  assign except_take = except && except_gate;

  // low 21 bits of the page field
  always_ff @(posedge clk) begin
    if (rst) begin
      proc <= '0;
    end else if (page_wr) begin
      proc <= csr_wr.data[60:40];
    end
  end

  // zero after reset means kernel
  always_ff @(posedge clk) begin
    if (rst) begin
      cpl <= cpl_kernel;
    end else if (except_take) begin
      // exception entry wins over a same-cycle mflags write
      cpl <= except_in_km ? cpl_kernel : cpl_user;
    end else if (mflags_wr) begin
      cpl <= csr_wr.data[1:0];
    end
  end

endmodule

`default_nettype wire

//--- logic/agu.sv
`default_nettype none

module agu #(
  parameter int tlb_ways = 4
) (
  input  logic                  clk,
  input  logic                  rst,
  input  agu_pkg::agu_req_t     req,
  input  logic                  req_en,
  input  logic                  except,
  input  logic                  except_gate,
  input  logic                  except_in_km,
  input  logic                  bus_hold,
  input  agu_pkg::bank_mask_t   other0_banks,
  input  agu_pkg::bank_mask_t   other1_banks,
  input  agu_pkg::bank_mask_t   otherR_banks,
  input  logic                  other_flip,
  input  dtlb_pkg::tlb_write_t  tlb_wr,
  input  dtlb_pkg::csr_write_t  csr_wr,
  output agu_pkg::mem_op_t      mem_op,
  output logic                  mem_op_en,
  output logic                  tlb_miss,
  output logic                  page_fault,
  output dtlb_pkg::fault_code_t fault_code,
  output logic                  conflict
);

  import agu_pkg::*;
  import dtlb_pkg::*;

  agu_req_t             req_q;
  logic                 valid_q;
  logic                 live;
  bank_mask_t           banks;
  bank_mask_t           granted;
  bank_idx_t            bank0;
  logic                 split;
  logic [page_bits:0]   next_off;
  logic                 page_carry;
  logic                 need_next;
  logic                 hit;
  logic                 hit_next;
  tlb_entry_t           entry;
  tlb_entry_t           entry_next;
  proc_id_t             proc;
  cpl_t                 cpl;
  ppn_t                 next_ppn;
  line_addr_t           this_line;
  line_addr_t           next_line;
  logic                 user;
  logic                 fault_this;
  logic                 fault_next;

  always_ff @(posedge clk) begin
    if (req_en) begin
      req_q <= req;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= req_en & ~except;
    end
  end

  // an exception in the output cycle kills the op
  assign live = valid_q & ~except;

  agu_bank_map u_bank_map (
    .op       (req_q.op),
    .addr_low (req_q.vaddr[6:0]),
    .banks    (banks),
    .bank0    (bank0),
    .split    (split)
  );

  agu_bank_conflict u_bank_conflict (
    .valid        (live),
    .banks        (banks),
    .other0_banks (other0_banks),
    .other1_banks (other1_banks),
    .otherR_banks (otherR_banks),
    .other_flip   (other_flip),
    .bus_hold     (bus_hold),
    .granted      (granted),
    .conflict     (conflict)
  );

  dtlb #(
    .tlb_ways (tlb_ways)
  ) u_dtlb (
    .clk        (clk),
    .rst        (rst),
    .proc       (proc),
    .vpn        (req_q.vaddr[43:13]),
    .hit        (hit),
    .entry      (entry),
    .hit_next   (hit_next),
    .entry_next (entry_next),
    .wr         (tlb_wr)
  );

  agu_mode_state u_mode_state (
    .clk          (clk),
    .rst          (rst),
    .csr_wr       (csr_wr),
    .except       (except),
    .except_gate  (except_gate),
    .except_in_km (except_in_km),
    .proc         (proc),
    .cpl          (cpl)
  );

  // next line offset, carry means the next page
  assign next_off = {1'b0, req_q.vaddr[page_bits-1:0]} + (page_bits + 1)'(line_bytes);
  assign page_carry = next_off[page_bits];
  assign need_next = split & page_carry;

  assign next_ppn = page_carry ? entry_next.ppn : entry.ppn;
  assign this_line = {entry.ppn, req_q.vaddr[12:8]};
  assign next_line = {next_ppn, next_off[12:8]};

  assign mem_op_en = live & hit & (~need_next | hit_next);
  assign tlb_miss = live & (~hit | (need_next & ~hit_next));

  assign user = cpl == cpl_user;
  assign fault_this = hit & ((entry.sys & user) | ~entry.perm);
  assign fault_next = need_next & hit_next & ((entry_next.sys & user) | ~entry_next.perm);

  always_comb begin
    fault_code = '0;
    fault_code[fault_this_bit] = live & fault_this;
    fault_code[fault_next_bit] = live & fault_next;
  end

  assign page_fault = ~bus_hold & (|fault_code);

  always_comb begin
    mem_op.op = req_q.op;
    mem_op.regno = req_q.regno;
    mem_op.lsq = req_q.lsq;
    mem_op.ii = req_q.ii;
    mem_op.wq = req_q.wq;
    mem_op.thread = req_q.thread;
    mem_op.lsflag = req_q.lsflag;
    mem_op.banks = mem_op_en ? granted : '0;
    mem_op.bank0 = bank0;
    mem_op.odd = req_q.vaddr[7];
    mem_op.addr_low = req_q.vaddr[1:0];
    mem_op.split = split;
    // odd flag swaps which line is even
    mem_op.addr_even = req_q.vaddr[7] ? next_line : this_line;
    mem_op.addr_odd = req_q.vaddr[7] ? this_line : next_line;
    mem_op.addr_main = {entry.ppn, req_q.vaddr[page_bits-1:0]};
    mem_op.mtype = entry.mtype;
  end

endmodule

`default_nettype wire

//--- test/agu_sva.sv
`default_nettype none

module agu_sva (
  input logic             clk,
  input logic             rst,
  input logic             except,
  input logic             mem_op_en,
  input logic             tlb_miss,
  input logic             page_fault,
  input logic             conflict,
  input agu_pkg::mem_op_t mem_op
);

  timeunit 1ns;
  timeprecision 100ps;

  // an op is either sent or reported missing, never both
  en_excludes_miss: assert property (@(posedge clk) disable iff (rst)
    !(mem_op_en && tlb_miss))
    else $error("mem_op_en and tlb_miss high in the same cycle");

  // no bank claims without a sent op
  idle_banks_empty: assert property (@(posedge clk) disable iff (rst)
    !mem_op_en |-> mem_op.banks == '0)
    else $error("mem_op banks not empty while mem_op_en is low");

  quiet_after_reset: assert property (@(posedge clk)
    rst |=> (!page_fault && !conflict))
    else $error("page_fault or conflict high in the cycle after reset");

  // exception in the request cycle blocks the op
  except_blocks_op: assert property (@(posedge clk) disable iff (rst)
    except |=> !mem_op_en)
    else $error("mem_op_en high in the cycle after an exception");

endmodule

bind agu agu_sva sva (.*);

`default_nettype wire

//--- test/agu_tb.sv
`default_nettype none

module agu_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import agu_pkg::*;
  import dtlb_pkg::*;

  // about 500 cycles of tests, with a wide margin
  localparam int max_cycles = 2000;

  localparam vpn_t vpn_a = 31'h0001_2340;
  localparam ppn_t ppn_a = 31'h0000_5a00;
  localparam ppn_t ppn_a1 = 31'h0000_77c3;
  localparam vpn_t vpn_b = 31'h0002_0000;
  localparam ppn_t ppn_b = 31'h0000_1234;
  localparam vpn_t vpn_c = 31'h0003_3333;
  localparam vpn_t vpn_f = 31'h0004_0100;
  localparam ppn_t ppn_f = 31'h0000_0f0f;
  localparam ppn_t ppn_f1 = 31'h0000_0e0e;
  localparam proc_id_t proc_new = 21'h1_2345;
  localparam ppn_t ppn_p = 31'h0000_3c3c;

  logic        clk;
  logic        rst;
  agu_req_t    req;
  logic        req_en;
  logic        except;
  logic        except_gate;
  logic        except_in_km;
  logic        bus_hold;
  bank_mask_t  other0_banks;
  bank_mask_t  other1_banks;
  bank_mask_t  otherR_banks;
  logic        other_flip;
  tlb_write_t  tlb_wr;
  csr_write_t  csr_wr;
  mem_op_t     mem_op;
  logic        mem_op_en;
  logic        tlb_miss;
  logic        page_fault;
  fault_code_t fault_code;
  logic        conflict;

  // attributes of page f and page f+1
  logic        f_sys;
  logic        f_perm;
  logic        f1_sys;
  logic        f1_perm;

  int checks = 0;
  int errors = 0;
  int cycles = 0;

  agu #(
    .tlb_ways (4)
  ) uut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == max_cycles) begin
      $display("timeout: run did not finish within %0d cycles", max_cycles);
      $display("Some tests failed");
      $finish;
    end
  end

  // size in bytes from the size code, 0 for fill-spill
  function automatic int size_of(input logic [4:0] code);
    case (code)
      5'd16: return 1;
      5'd17: return 2;
      5'd18, 5'd4, 5'd5, 5'd6: return 4;
      5'd3: return 10;
      5'd0, 5'd1, 5'd2, 5'd12, 5'd13, 5'd14: return 16;
      5'd15: return 0;
      default: return 8;
    endcase
  endfunction

  function automatic int bank_span(input logic [4:0] code, input logic [1:0] off);
    if (code == 5'd15) begin
      return 5;
    end
    return (int'(off) + size_of(code) + 3) / 4;
  endfunction

  function automatic bank_mask_t model_banks(input logic [4:0] code, input logic [6:0] low);
    bank_mask_t m;
    int first;
    int n;
    m = '0;
    first = int'(low[6:2]);
    n = bank_span(code, low[1:0]);
    for (int k = 0; k < n; k++) begin
      m[(first + k) % bank_count] = 1'b1;
    end
    return m;
  endfunction

  function automatic logic model_split(input logic [4:0] code, input logic [6:0] low);
    return int'(low[6:2]) + bank_span(code, low[1:0]) > bank_count;
  endfunction

  function automatic logic page_faults(input logic sys, input logic perm, input logic is_user);
    return (sys && is_user) || !perm;
  endfunction

  function automatic op_t make_op(input logic [4:0] code, input logic store);
    return {7'b0, code, store};
  endfunction

  function automatic logic [63:0] make_va(input vpn_t vpn, input logic [12:0] off);
    return {20'h0, vpn, off};
  endfunction

  task automatic check_banks(input bank_mask_t got, input bank_mask_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_idx(input bank_idx_t got, input bank_idx_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_paddr(input line_addr_t got, input line_addr_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_main(input logic [paddr_width-1:0] got,
                            input logic [paddr_width-1:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_mtype(input logic [1:0] got, input logic [1:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_fault(input fault_code_t got, input fault_code_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // tags and low address bits pass straight through
  task automatic check_tags(input mem_op_t got, input agu_req_t sent, input string what);
    checks++;
    if (got.op !== sent.op || got.regno !== sent.regno || got.lsq !== sent.lsq ||
        got.ii !== sent.ii || got.wq !== sent.wq || got.thread !== sent.thread ||
        got.lsflag !== sent.lsflag || got.odd !== sent.vaddr[7] ||
        got.addr_low !== sent.vaddr[1:0]) begin
      errors++;
      $display("Fail at %0t: %s got op %h reg %h lsq %h expected op %h reg %h lsq %h",
               $time, what, got.op, got.regno, got.lsq, sent.op, sent.regno, sent.lsq);
    end
  endtask

  task automatic tlb_write(input int way, input proc_id_t pid, input vpn_t vpn,
                           input ppn_t ppn, input logic sys, input logic perm);
    @(posedge clk);
    #1;
    tlb_wr.valid = 1'b1;
    tlb_wr.way = 3'(way);
    tlb_wr.proc = pid;
    tlb_wr.vpn = vpn;
    tlb_wr.entry.ppn = ppn;
    tlb_wr.entry.mtype = 2'(way);
    tlb_wr.entry.sys = sys;
    tlb_wr.entry.perm = perm;
    @(posedge clk);
    #1;
    tlb_wr.valid = 1'b0;
  endtask

  task automatic map_fault_pages(input logic sys0, input logic perm0,
                                 input logic sys1, input logic perm1);
    f_sys = sys0;
    f_perm = perm0;
    f1_sys = sys1;
    f1_perm = perm1;
    tlb_write(2, '0, vpn_f, ppn_f, sys0, perm0);
    tlb_write(3, '0, vpn_f + 31'd1, ppn_f1, sys1, perm1);
  endtask

  task automatic csr_write(input logic [15:0] no, input logic [63:0] data);
    @(posedge clk);
    #1;
    csr_wr.en = 1'b1;
    csr_wr.no = no;
    csr_wr.data = data;
    @(posedge clk);
    #1;
    csr_wr.en = 1'b0;
  endtask

  task automatic take_exception(input logic in_km);
    @(posedge clk);
    #1;
    except = 1'b1;
    except_gate = 1'b1;
    except_in_km = in_km;
    @(posedge clk);
    #1;
    except = 1'b0;
    except_gate = 1'b0;
  endtask

  task automatic set_others(input bank_mask_t o0, input bank_mask_t o1, input bank_mask_t o_r,
                            input logic flip, input logic hold);
    @(posedge clk);
    #1;
    other0_banks = o0;
    other1_banks = o1;
    otherR_banks = o_r;
    other_flip = flip;
    bus_hold = hold;
  endtask

  // strobe one request and stop at a stable point of the output cycle
  task automatic issue(input op_t op, input logic [63:0] va,
                       input logic exc_req, input logic exc_out);
    @(posedge clk);
    #1;
    req = '0;
    req.op = op;
    req.vaddr = va;
    req.regno = reg_no_t'($urandom);
    req.lsq = lsq_no_t'($urandom);
    req.ii = ii_no_t'($urandom);
    req.wq = wq_no_t'($urandom);
    req.thread = 1'($urandom);
    req.lsflag = 1'($urandom);
    req_en = 1'b1;
    except = exc_req;
    @(posedge clk);
    #1;
    req_en = 1'b0;
    except = exc_out;
    #2;
  endtask

  task automatic access(input op_t op, input logic [63:0] va,
                        input logic exp_en, input logic exp_miss);
    issue(op, va, 1'b0, 1'b0);
    check_bit(mem_op_en, exp_en, "mem_op_en");
    check_bit(tlb_miss, exp_miss, "tlb_miss");
    check_tags(mem_op, req, "pass-through fields");
  endtask

  task automatic check_xlate(input logic [63:0] va, input ppn_t ppn_this, input ppn_t ppn_next,
                             input logic [1:0] mtype);
    logic [13:0] noff;
    line_addr_t  this_l;
    line_addr_t  next_l;
    noff = {1'b0, va[12:0]} + 14'd128;
    this_l = {ppn_this, va[12:8]};
    next_l = {noff[13] ? ppn_next : ppn_this, noff[12:8]};
    check_paddr(mem_op.addr_even, va[7] ? next_l : this_l, "even line");
    check_paddr(mem_op.addr_odd, va[7] ? this_l : next_l, "odd line");
    check_main(mem_op.addr_main, {ppn_this, va[12:0]}, "main address");
    check_mtype(mem_op.mtype, mtype, "memory type");
  endtask

  task automatic fault_access(input logic [12:0] off, input logic [4:0] code,
                              input logic is_user);
    logic [13:0] noff;
    logic        need_next;
    fault_code_t exp;
    noff = {1'b0, off} + 14'd128;
    need_next = model_split(code, off[6:0]) && noff[13];
    exp = '0;
    exp[0] = page_faults(f_sys, f_perm, is_user);
    exp[1] = need_next && page_faults(f1_sys, f1_perm, is_user);
    access(make_op(code, 1'b0), make_va(vpn_f, off), 1'b1, 1'b0);
    check_fault(fault_code, exp, "fault code");
    check_bit(page_fault, |exp, "page_fault");
  endtask

  task automatic sweep_sizes();
    logic [12:0] low;
    for (int c = 0; c < 32; c++) begin
      for (int rep = 0; rep < 4; rep++) begin
        low = 13'($urandom);
        access(make_op(5'(c), 1'($urandom)), make_va(vpn_a, low), 1'b1, 1'b0);
        check_banks(mem_op.banks, model_banks(5'(c), low[6:0]), "bank mask");
        check_idx(mem_op.bank0, bank_idx_t'(low[6:2]), "first bank");
        check_bit(mem_op.split, model_split(5'(c), low[6:0]), "split");
      end
    end
  endtask

  task automatic translate_pages();
    access(make_op(5'd18, 1'b0), make_va(vpn_a, 13'h0400), 1'b1, 1'b0);
    check_xlate(make_va(vpn_a, 13'h0400), ppn_a, ppn_a1, 2'd0);
    access(make_op(5'd18, 1'b1), make_va(vpn_a, 13'h0480), 1'b1, 1'b0);
    check_xlate(make_va(vpn_a, 13'h0480), ppn_a, ppn_a1, 2'd0);
    // quad at bank 30 of the last line wraps into the next page
    access(make_op(5'd0, 1'b0), make_va(vpn_a, 13'h1ff8), 1'b1, 1'b0);
    check_bit(mem_op.split, 1'b1, "split at page end");
    check_xlate(make_va(vpn_a, 13'h1ff8), ppn_a, ppn_a1, 2'd0);
    access(make_op(5'd16, 1'b0), make_va(vpn_a, 13'h1f84), 1'b1, 1'b0);
    check_xlate(make_va(vpn_a, 13'h1f84), ppn_a, ppn_a1, 2'd0);
    access(make_op(5'd18, 1'b0), make_va(vpn_c, 13'h0200), 1'b0, 1'b1);
    tlb_write(2, '0, vpn_b, ppn_b, 1'b0, 1'b1);
    access(make_op(5'd19, 1'b0), make_va(vpn_b, 13'h0a10), 1'b1, 1'b0);
    check_xlate(make_va(vpn_b, 13'h0a10), ppn_b, ppn_b, 2'd2);
    // next page of b is unmapped
    access(make_op(5'd19, 1'b0), make_va(vpn_b, 13'h1ffc), 1'b0, 1'b1);
  endtask

  task automatic fault_levels();
    // page f system only, page f+1 not permitted
    map_fault_pages(1'b1, 1'b1, 1'b0, 1'b0);
    csr_write(csr_mflags, 64'(cpl_user));
    fault_access(13'h0100, 5'd16, 1'b1);
    fault_access(13'h1ffc, 5'd19, 1'b1);
    csr_write(csr_mflags, 64'(cpl_kernel));
    fault_access(13'h0100, 5'd16, 1'b0);
    fault_access(13'h1ffc, 5'd19, 1'b0);
    take_exception(1'b0);
    fault_access(13'h0100, 5'd16, 1'b1);
    take_exception(1'b1);
    fault_access(13'h0100, 5'd16, 1'b0);
    // roles swapped between the two pages
    map_fault_pages(1'b0, 1'b0, 1'b1, 1'b1);
    fault_access(13'h0100, 5'd16, 1'b0);
    fault_access(13'h1ffc, 5'd19, 1'b0);
    take_exception(1'b0);
    fault_access(13'h1ffc, 5'd19, 1'b1);
    take_exception(1'b1);
    fault_access(13'h1ffc, 5'd19, 1'b0);
  endtask

  task automatic switch_process();
    csr_write(csr_page, 64'(proc_new) << 40);
    access(make_op(5'd18, 1'b0), make_va(vpn_a, 13'h0400), 1'b0, 1'b1);
    tlb_write(3, proc_new, vpn_a, ppn_p, 1'b0, 1'b1);
    access(make_op(5'd18, 1'b0), make_va(vpn_a, 13'h0400), 1'b1, 1'b0);
    check_xlate(make_va(vpn_a, 13'h0400), ppn_p, ppn_p, 2'd3);
    csr_write(csr_page, 64'h0);
    access(make_op(5'd18, 1'b0), make_va(vpn_a, 13'h0400), 1'b1, 1'b0);
    check_xlate(make_va(vpn_a, 13'h0400), ppn_a, ppn_a1, 2'd0);
  endtask

  task automatic filter_conflicts();
    logic [12:0] low;
    logic [4:0]  code;
    bank_mask_t  o0;
    bank_mask_t  o1;
    bank_mask_t  o_r;
    bank_mask_t  claimed;
    bank_mask_t  lost;
    logic        flip;
    for (int t = 0; t < 16; t++) begin
      low = 13'($urandom);
      code = 5'($urandom);
      o0 = $urandom & $urandom;
      o1 = $urandom & $urandom;
      o_r = $urandom & $urandom & $urandom;
      flip = t[0];
      set_others(o0, o1, o_r, flip, 1'b0);
      access(make_op(code, 1'b0), make_va(vpn_a, low), 1'b1, 1'b0);
      claimed = model_banks(code, low[6:0]);
      lost = claimed & (o_r | (flip ? o1 : o0));
      check_banks(mem_op.banks, claimed & ~lost, "granted banks");
      check_bit(conflict, |lost, "conflict");
    end
    // held bus with a faulting page and every bank taken
    csr_write(csr_mflags, 64'(cpl_user));
    set_others('1, '1, '1, 1'b0, 1'b1);
    access(make_op(5'd16, 1'b0), make_va(vpn_f, 13'h0100), 1'b1, 1'b0);
    check_bit(conflict, 1'b0, "conflict under bus_hold");
    check_bit(page_fault, 1'b0, "page_fault under bus_hold");
    check_banks(mem_op.banks, '0, "granted banks under bus_hold");
    set_others('0, '0, '0, 1'b0, 1'b0);
    csr_write(csr_mflags, 64'(cpl_kernel));
  endtask

  task automatic cancel_by_exception();
    issue(make_op(5'd18, 1'b0), make_va(vpn_a, 13'h0400), 1'b1, 1'b0);
    check_bit(mem_op_en, 1'b0, "mem_op_en after request-cycle except");
    issue(make_op(5'd18, 1'b0), make_va(vpn_c, 13'h0400), 1'b1, 1'b0);
    check_bit(tlb_miss, 1'b0, "tlb_miss after request-cycle except");
    issue(make_op(5'd18, 1'b0), make_va(vpn_a, 13'h0400), 1'b0, 1'b1);
    check_bit(mem_op_en, 1'b0, "mem_op_en under output-cycle except");
    issue(make_op(5'd18, 1'b0), make_va(vpn_c, 13'h0400), 1'b0, 1'b1);
    check_bit(tlb_miss, 1'b0, "tlb_miss under output-cycle except");
    access(make_op(5'd18, 1'b0), make_va(vpn_a, 13'h0400), 1'b1, 1'b0);
  endtask

  initial begin
    void'($urandom(32'h508994a0));
    rst = 1'b1;
    req = '0;
    req_en = 1'b0;
    except = 1'b0;
    except_gate = 1'b0;
    except_in_km = 1'b0;
    bus_hold = 1'b0;
    other0_banks = '0;
    other1_banks = '0;
    otherR_banks = '0;
    other_flip = 1'b0;
    tlb_wr = '0;
    csr_wr = '0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    #2;
    check_bit(mem_op_en, 1'b0, "mem_op_en after reset");
    check_bit(tlb_miss, 1'b0, "tlb_miss after reset");
    check_bit(page_fault, 1'b0, "page_fault after reset");
    check_bit(conflict, 1'b0, "conflict after reset");
    tlb_write(0, '0, vpn_a, ppn_a, 1'b0, 1'b1);
    tlb_write(1, '0, vpn_a + 31'd1, ppn_a1, 1'b0, 1'b1);
    sweep_sizes();
    translate_pages();
    fault_levels();
    switch_process();
    filter_conflicts();
    cancel_by_exception();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
logic/agu_pkg.sv
logic/dtlb_pkg.sv
logic/agu_bank_map.sv
logic/agu_bank_conflict.sv
logic/dtlb.sv
logic/agu_mode_state.sv
logic/agu.sv
test/agu_sva.sv
test/agu_tb.sv

//--- Bender.yml
package:
  name: agu

sources:
  - logic/agu_pkg.sv
  - logic/dtlb_pkg.sv
  - logic/agu_bank_map.sv
  - logic/agu_bank_conflict.sv
  - logic/dtlb.sv
  - logic/agu_mode_state.sv
  - logic/agu.sv
  - target: test
    files:
      - test/agu_sva.sv
      - test/agu_tb.sv
